//--- sifhPkg.sv
`default_nettype none

package sifhPkg;

    // raw timestamp from the pixel front end
    localparam int TS_WIDTH = 12;

    // histogram address width
    // coarse bin = top bits, fine bin = bottom bits
    localparam int BIN_WIDTH = 6;

    // one histogram entry per bin address
    localparam int NUM_BINS = 64;

    // per-bin event count, saturating
    localparam int COUNT_WIDTH = 21;

    // timestamps taken per pass
    localparam int ACQ_WIDTH = 16;

    typedef logic [TS_WIDTH-1:0] timestampT;
    typedef logic [BIN_WIDTH-1:0] binT;
    typedef logic [COUNT_WIDTH-1:0] countT;
    typedef logic [ACQ_WIDTH-1:0] acqLenT;

    // pass sequencing states of sifhControl
    typedef enum logic [2:0] {
        stIdle,
        stClear,
        stAccum,
        stDrain,
        stScan,
        stSettle,
        stResult
    } ctrlStateT;

endpackage

`default_nettype wire

//--- eventGate.sv
`timescale 1ns/10ps
`default_nettype none

module eventGate import sifhPkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      enable,
    input  wire acqLenT    acqLength,
    input  wire logic      passFine,
    input  wire binT       coarsePeak,
    input  wire timestampT ts,
    input  wire logic      tsValid,
    output logic           tsReady,
    output logic           acqFinish,
    output logic           incValid,
    output binT            incBin
);

    // timestamps taken so far in this pass
    acqLenT takenCount;
    // pass length, frozen while the gate is open
    acqLenT lenReg;
    logic   take;
    binT    coarseBin;
    binT    fineBin;
    logic   inPeak;

    // open only during accumulate and until the pass is full
    assign tsReady = enable && (takenCount < lenReg);
    assign take    = tsValid && tsReady;

    // pulse on the transfer that fills the pass
    assign acqFinish = take && (acqLenT'(takenCount + 1'b1) == lenReg);

    // bin split of the timestamp
    assign coarseBin = ts[TS_WIDTH-1 -: BIN_WIDTH];
    assign fineBin   = ts[BIN_WIDTH-1:0];

    // fine pass keeps only hits inside the coarse peak
    assign inPeak = (coarseBin == coarsePeak);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            takenCount <= '0;
            lenReg     <= '0;
            incValid   <= 1'b0;
        end else begin
            if (!enable) begin
                // gate closed, so the next rising enable starts from zero
                takenCount <= '0;
                lenReg     <= acqLength;
            end else if (take) begin
                takenCount <= takenCount + 1'b1;
            end
            // dropped fine-pass hits still count toward the length above
            incValid <= take && (!passFine || inPeak);
        end
    end

    // bin address registered alongside incValid
    always_ff @(posedge clk) begin
        if (take) begin
            incBin <= passFine ? fineBin : coarseBin;
        end
    end

endmodule

`default_nettype wire

//--- histogramMemory.sv
`timescale 1ns/10ps
`default_nettype none

module histogramMemory import sifhPkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  clearEn,
    input  wire binT   clearBin,
    input  wire logic  incValid,
    input  wire binT   incBin,
    input  wire logic  scanEn,
    input  wire binT   scanBin,
    output logic       scanValid,
    output binT        scanBinOut,
    output countT      scanCount
);

    // count storage, one write port
    countT mem [NUM_BINS];

    // increment read stage
    logic  s1Valid;
    binT   s1Bin;
    countT rdData;

    // copy of the last write, for back-to-back hits
    logic  fwdValid;
    binT   fwdBin;
    countT fwdData;

    countT baseCount;
    countT nextCount;
    logic  wrEn;
    binT   wrBin;
    countT wrData;

    // stage one: read the current count of the hit bin
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= incValid && !clearEn;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= incBin;
        rdData <= mem[incBin];
    end

    // the read above missed a write landing on the same edge
    always_comb begin
        if (fwdValid && (fwdBin == s1Bin)) begin
            baseCount = fwdData;
        end else begin
            baseCount = rdData;
        end
    end

    // hold at all ones
    assign nextCount = (&baseCount) ? baseCount : countT'(baseCount + 1'b1);

    // clear sweep has the port, increments never overlap it
    assign wrEn   = clearEn || s1Valid;
    assign wrBin  = clearEn ? clearBin : s1Bin;
    assign wrData = clearEn ? '0 : nextCount;

    // stage two: write back
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrBin] <= wrData;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fwdValid <= 1'b0;
        end else begin
            fwdValid <= wrEn;
        end
    end

    always_ff @(posedge clk) begin
        fwdBin  <= wrBin;
        fwdData <= wrData;
    end

    // scan read-out, address delayed to line up with data
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scanValid <= 1'b0;
        end else begin
            scanValid <= scanEn;
        end
    end

    always_ff @(posedge clk) begin
        scanBinOut <= scanBin;
        scanCount  <= mem[scanBin];
    end

endmodule

`default_nettype wire

//--- peakDetector.sv
`timescale 1ns/10ps
`default_nettype none

module peakDetector import sifhPkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  scanValid,
    input  wire binT   scanBin,
    input  wire countT scanCount,
    output binT        peakBin,
    output countT      peakCount
);

    // bin zero opens a new scan
    logic restart;
    // strictly greater, so ties keep the lower bin
    logic greater;

    assign restart = (scanBin == '0);
    assign greater = (scanCount > peakCount);

    // running maximum over the scan
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (scanValid) begin
            if (restart || greater) begin
                // first entry seeds the max, even a zero count
                peakBin   <= scanBin;
                peakCount <= scanCount;
            end
        end
    end

endmodule

`default_nettype wire

//--- sifhControl.sv
`timescale 1ns/10ps
`default_nettype none

module sifhControl import sifhPkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   start,
    input  wire acqLenT acqLength,
    output logic        busy,
    input  wire logic   tsReady,
    output logic        gateEnable,
    output logic        passFine,
    output binT         coarsePeak,
    input  wire logic   acqFinish,
    output logic        clearEn,
    output binT         clearBin,
    output logic        scanEn,
    output binT         scanBin,
    input  wire binT    peakBin,
    input  wire countT  peakCount,
    output logic        resultValid,
    input  wire logic   resultReady,
    output binT         peakCoarse,
    output binT         peakFine,
    output countT       peakCountOut
);

    ctrlStateT state;
    // shared address for the clear and scan sweeps
    binT       sweepAddr;
    // drain wait, three cycles
    logic [1:0] drainCnt;
    acqLenT    acqLenReg;
    // high the cycle after settle, peak detector output is final
    logic      latchNow;
    logic      sweepLast;
    logic      emptyPass;

    assign sweepLast = &sweepAddr;

    // zero length pass, gate never opens
    assign emptyPass = (acqLenReg == '0) && !tsReady;

    assign busy       = (state != stIdle);
    assign gateEnable = (state == stAccum);
    assign clearEn    = (state == stClear);
    assign clearBin   = sweepAddr;
    assign scanEn     = (state == stScan);
    assign scanBin    = sweepAddr;

    // coarse result is also the fine pass filter
    assign peakCoarse = coarsePeak;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= stIdle;
            sweepAddr   <= '0;
            drainCnt    <= '0;
            acqLenReg   <= '0;
            passFine    <= 1'b0;
            latchNow    <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            latchNow <= (state == stSettle);
            case (state)
                stIdle: begin
                    // start only seen here
                    if (start) begin
                        acqLenReg <= acqLength;
                        passFine  <= 1'b0;
                        sweepAddr <= '0;
                        state     <= stClear;
                    end
                end
                stClear: begin
                    // wraps back to zero for the scan
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepLast) begin
                        state <= stAccum;
                    end
                end
                stAccum: begin
                    if (acqFinish || emptyPass) begin
                        drainCnt <= '0;
                        state    <= stDrain;
                    end
                end
                stDrain: begin
                    // gate register, RAM read, RAM write
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == 2'd2) begin
                        state <= stScan;
                    end
                end
                stScan: begin
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepLast) begin
                        state <= stSettle;
                    end
                end
                stSettle: begin
                    // last scan count reaches the detector here
                    if (passFine) begin
                        state <= stResult;
                    end else begin
                        passFine <= 1'b1;
                        state    <= stClear;
                    end
                end
                stResult: begin
                    if (latchNow) begin
                        resultValid <= 1'b1;
                    end else if (resultValid && resultReady) begin
                        resultValid <= 1'b0;
                        state       <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // peak capture, coarse while the fine clear sweep runs
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            coarsePeak   <= '0;
            peakFine     <= '0;
            peakCountOut <= '0;
        end else if (latchNow) begin
            if (state == stResult) begin
                peakFine     <= peakBin;
                peakCountOut <= peakCount;
            end else begin
                coarsePeak <= peakBin;
            end
        end
    end

endmodule

`default_nettype wire

//--- sifhTop.sv
`timescale 1ns/10ps
`default_nettype none

module sifhTop import sifhPkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      start,
    input  wire acqLenT    acqLength,
    input  wire timestampT ts,
    input  wire logic      tsValid,
    output logic           tsReady,
    output logic           resultValid,
    input  wire logic      resultReady,
    output binT            peakCoarse,
    output binT            peakFine,
    output countT          peakCount,
    output logic           busy
);

    // control to gate
    logic  gateEnable;
    logic  passFine;
    binT   coarsePeak;
    logic  acqFinish;

    // gate to memory
    logic  incValid;
    binT   incBin;

    // control to memory
    logic  clearEn;
    binT   clearBin;
    logic  scanEn;
    binT   scanBin;

    // memory to detector
    logic  scanValid;
    binT   scanBinOut;
    countT scanCount;

    // detector back to control
    binT   detPeakBin;
    countT detPeakCount;

    sifhControl sifhControl_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .acqLength    (acqLength),
        .busy         (busy),
        .tsReady      (tsReady),
        .gateEnable   (gateEnable),
        .passFine     (passFine),
        .coarsePeak   (coarsePeak),
        .acqFinish    (acqFinish),
        .clearEn      (clearEn),
        .clearBin     (clearBin),
        .scanEn       (scanEn),
        .scanBin      (scanBin),
        .peakBin      (detPeakBin),
        .peakCount    (detPeakCount),
        .resultValid  (resultValid),
        .resultReady  (resultReady),
        .peakCoarse   (peakCoarse),
        .peakFine     (peakFine),
        .peakCountOut (peakCount)
    );

    eventGate eventGate_i (
        .clk        (clk),
        .reset      (reset),
        .enable     (gateEnable),
        .acqLength  (acqLength),
        .passFine   (passFine),
        .coarsePeak (coarsePeak),
        .ts         (ts),
        .tsValid    (tsValid),
        .tsReady    (tsReady),
        .acqFinish  (acqFinish),
        .incValid   (incValid),
        .incBin     (incBin)
    );

    histogramMemory histogramMemory_i (
        .clk        (clk),
        .reset      (reset),
        .clearEn    (clearEn),
        .clearBin   (clearBin),
        .incValid   (incValid),
        .incBin     (incBin),
        .scanEn     (scanEn),
        .scanBin    (scanBin),
        .scanValid  (scanValid),
        .scanBinOut (scanBinOut),
        .scanCount  (scanCount)
    );

    peakDetector peakDetector_i (
        .clk       (clk),
        .reset     (reset),
        .scanValid (scanValid),
        .scanBin   (scanBinOut),
        .scanCount (scanCount),
        .peakBin   (detPeakBin),
        .peakCount (detPeakCount)
    );

endmodule

`default_nettype wire

//--- sifhTb.sv
`timescale 1ns/10ps
`default_nettype none

module sifhTb import sifhPkg::*; ();

    // one row of stimulus
    typedef struct packed {
        int len;
        int center;
        // pass two center or the odd-index center in alternate mode
        int center2;
        int spread;
        // percent of uniform noise hits
        int noise;
        // alternate centers by index instead of by pass
        int alt;
        // idle cycles after each transfer
        int gap;
        // cycles before resultReady
        int delay;
    } rowT;

    localparam int NUM_ROWS = 8;

    // len, center, center2, spread, noise, alt, gap, delay
    localparam rowT stimTable [NUM_ROWS] = '{
        '{40, 'h5a3, 'h5a3, 3, 10, 0, 0, 0},
        // identical hits back to back
        '{24, 'h1f0, 'h1f0, 0, 0, 0, 0, 0},
        // equal coarse maxima in bins 27 and 10
        '{8, 'h6c3, 'h2a5, 0, 0, 1, 0, 1},
        '{30, 'h9e7, 'h9e7, 5, 25, 0, 2, 7},
        // second pass wholly outside the coarse peak
        '{16, 'h400, 'h800, 0, 0, 0, 1, 3},
        '{0, 'h123, 'h123, 2, 20, 0, 0, 2},
        '{64, 'hc2e, 'hc2e, 8, 50, 0, 0, 0},
        // straddles the coarse 0/1 boundary
        '{48, 'h03a, 'h03a, 12, 15, 0, 1, 1}
    };

    logic      clk;
    logic      reset;
    logic      start;
    acqLenT    acqLength;
    timestampT ts;
    logic      tsValid;
    logic      tsReady;
    logic      resultValid;
    logic      resultReady;
    binT       peakCoarse;
    binT       peakFine;
    countT     peakCount;
    logic      busy;

    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          curRow;

    sifhTop sifhTop_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .acqLength   (acqLength),
        .ts          (ts),
        .tsValid     (tsValid),
        .tsReady     (tsReady),
        .resultValid (resultValid),
        .resultReady (resultReady),
        .peakCoarse  (peakCoarse),
        .peakFine    (peakFine),
        .peakCount   (peakCount),
        .busy        (busy)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compareValue(input string what, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0t row %0d: %s got %0d expected %0d", $time, curRow, what,
                     got, exp);
        end
    endtask

    // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic int takeBits(input int n);
        int   r;
        int   i;
        logic fb;
        r = 0;
        for (i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic timestampT makeTimestamp(input rowT r, input int j);
        int center;
        int offset;
        if (takeBits(7) % 100 < r.noise) begin
            return timestampT'(takeBits(TS_WIDTH));
        end
        if (r.alt != 0) begin
            center = (j % 2 != 0) ? r.center2 : r.center;
        end else begin
            center = (j < r.len) ? r.center : r.center2;
        end
        offset = takeBits(8) % (2 * r.spread + 1) - r.spread;
        return timestampT'(center + offset);
    endfunction

    // first highest entry wins a tie
    function automatic int firstMax(input int hist [NUM_BINS]);
        int best;
        int b;
        best = 0;
        for (b = 1; b < NUM_BINS; b++) begin
            if (hist[b] > hist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    // reference model over what was actually transferred
    task automatic modelPeaks(input int len, input timestampT got[$], output int expCoarse,
                              output int expFine, output int expCount);
        int  coarseHist [NUM_BINS];
        int  fineHist [NUM_BINS];
        binT hitBin;
        int  k;
        for (k = 0; k < NUM_BINS; k++) begin
            coarseHist[k] = 0;
            fineHist[k] = 0;
        end
        for (k = 0; k < len && k < got.size(); k++) begin
            hitBin = got[k][TS_WIDTH-1 -: BIN_WIDTH];
            coarseHist[hitBin]++;
        end
        expCoarse = firstMax(coarseHist);
        // second pass keeps only the coarse peak
        for (k = len; k < got.size(); k++) begin
            hitBin = got[k][TS_WIDTH-1 -: BIN_WIDTH];
            if (int'(hitBin) == expCoarse) begin
                hitBin = got[k][BIN_WIDTH-1:0];
                fineHist[hitBin]++;
            end
        end
        expFine = firstMax(fineHist);
        expCount = fineHist[expFine];
    endtask

    task automatic runRow(input int n);
        rowT       r;
        timestampT stim[$];
        timestampT got[$];
        int        j;
        int        d;
        int        expCoarse;
        int        expFine;
        int        expCount;
        r = stimTable[n];
        curRow = n;
        for (j = 0; j < 2 * r.len; j++) begin
            stim.push_back(makeTimestamp(r, j));
        end
        // acqLength stays put for the whole run
        @(negedge clk);
        acqLength = acqLenT'(r.len);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        j = 0;
        while (j < 2 * r.len) begin
            ts = stim[j];
            tsValid = 1'b1;
            if (tsReady) begin
                // taken on the coming rising edge
                got.push_back(stim[j]);
                j++;
                @(negedge clk);
                if (j == r.len || j == 2 * r.len) begin
                    compareValue("tsReady after full pass", int'(tsReady), 0);
                end
                tsValid = 1'b0;
                repeat (r.gap) @(negedge clk);
            end else begin
                @(negedge clk);
            end
        end
        // keep offering so any extra transfer is counted
        ts = '1;
        tsValid = 1'b1;
        while (!resultValid) begin
            if (tsReady) begin
                got.push_back(ts);
            end
            @(negedge clk);
        end
        tsValid = 1'b0;
        modelPeaks(r.len, got, expCoarse, expFine, expCount);
        compareValue("transfers per run", got.size(), 2 * r.len);
        for (d = 0; d <= r.delay; d++) begin
            // resultValid is known high on entry
            if (d > 0) begin
                compareValue("resultValid held", int'(resultValid), 1);
            end
            compareValue("busy while result pending", int'(busy), 1);
            compareValue("peakCoarse", int'(peakCoarse), expCoarse);
            compareValue("peakFine", int'(peakFine), expFine);
            compareValue("peakCount", int'(peakCount), expCount);
            // start pulse while busy has no effect
            start = (d == 0) && (r.delay > 0);
            resultReady = (d == r.delay);
            @(negedge clk);
        end
        start = 1'b0;
        resultReady = 1'b0;
        compareValue("resultValid after handshake", int'(resultValid), 0);
        compareValue("busy after handshake", int'(busy), 0);
    endtask

    initial begin
        reset = 1'b0;
        start = 1'b0;
        acqLength = '0;
        ts = '0;
        tsValid = 1'b0;
        resultReady = 1'b0;
        lfsrState = 32'h8be0;
        errorCount = 0;
        checkCount = 0;
        curRow = -1;
        repeat (10) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        compareValue("tsReady after reset", int'(tsReady), 0);
        compareValue("resultValid after reset", int'(resultValid), 0);
        compareValue("busy after reset", int'(busy), 0);
        for (int n = 0; n < NUM_ROWS; n++) begin
            runRow(n);
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // two passes of transfers plus sweeps per row and the result delay
    initial begin
        int        limit;
        ctrlStateT st;
        limit = 10 + 200;
        for (int n = 0; n < NUM_ROWS; n++) begin
            limit += 2 * (stimTable[n].len * (stimTable[n].gap + 1) + 140) + stimTable[n].delay;
        end
        repeat (limit) @(posedge clk);
        st = sifhTop_i.sifhControl_i.state;
        $display("timeout: run did not end within %0d cycles, row %0d, control state %s",
                 limit, curRow, st.name());
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
sifhPkg.sv
eventGate.sv
histogramMemory.sv
peakDetector.sv
sifhControl.sv
sifhTop.sv
sifhTb.sv

//--- Makefile
# Verilator build and run of the time-of-flight peak finder testbench

SIM  := obj_dir/VsifhTb
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(SIM): compile.f $(SRCS)
	verilator --binary --timing -j 0 --top-module sifhTb -f compile.f

run: $(SIM)
	./$(SIM) > sim.log; cat sim.log

# pass only if the log holds the pass line
check: run
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
